// File: common/exPkg.sv
// Execute back end shared definitions
// Opcodes, extension codes, condition codes, queue kinds,
// widths, queue depth and trap codes used by EX1 and EX2
package exPkg;

	// Datapath widths
	localparam int DataWidth = 64;
	localparam int AddrWidth = 32;
	localparam int RegIdWidth = 6;
	localparam logic [RegIdWidth-1:0] RegZero = 6'd0;	// No destination

	// Queue between EX1 and EX2, also the credit count
	localparam int QueueDepth = 4;
	localparam int QueuePtrWidth = $clog2(QueueDepth);
	localparam int CreditWidth = $clog2(QueueDepth + 1);

	// Scratchpad of quadwords, indexed by address bits 10:3
	localparam int MemWords = 256;
	localparam int MemIdxWidth = $clog2(MemWords);

	localparam logic [AddrWidth-1:0] SpReset = 32'h800;

	// Opcodes, opUCmd[5:0]
	localparam logic [5:0] UcmdNop = 6'h00;
	localparam logic [5:0] UcmdInvop = 6'h01;
	localparam logic [5:0] UcmdLea = 6'h02;
	localparam logic [5:0] UcmdStore = 6'h03;
	localparam logic [5:0] UcmdLoad = 6'h04;
	localparam logic [5:0] UcmdPush = 6'h05;
	localparam logic [5:0] UcmdPop = 6'h06;
	localparam logic [5:0] UcmdMovIr = 6'h07;
	localparam logic [5:0] UcmdShad = 6'h08;
	localparam logic [5:0] UcmdShld = 6'h09;
	localparam logic [5:0] UcmdCmpEq = 6'h0A;
	localparam logic [5:0] UcmdBra = 6'h0B;
	localparam logic [5:0] UcmdJmp = 6'h0C;
	localparam logic [5:0] UcmdOpIxt = 6'h0D;

	// Extension codes under UcmdOpIxt, opUIxt[5:0]
	localparam logic [5:0] IxtClrt = 6'h01;
	localparam logic [5:0] IxtSett = 6'h02;
	localparam logic [5:0] IxtNott = 6'h03;
	localparam logic [5:0] IxtMovt = 6'h04;
	localparam logic [5:0] IxtTrapa = 6'h05;

	// Condition codes, opUCmd[7:6]
	localparam logic [1:0] CcAlways = 2'b00;
	localparam logic [1:0] CcNever = 2'b01;
	localparam logic [1:0] CcTrue = 2'b10;
	localparam logic [1:0] CcFalse = 2'b11;

	// Trap codes
	localparam logic [15:0] TrapInvalid = 16'hC000;
	localparam logic [15:0] TrapTrapa = 16'hC080;	// Plus regIdRm[3:0]

	// Queue entry kinds
	localparam logic [1:0] KindReg = 2'd0;
	localparam logic [1:0] KindLoad = 2'd1;
	localparam logic [1:0] KindStore = 2'd2;
	localparam logic [1:0] KindNone = 2'd3;

endpackage

// File: rtl/exAddrGen.sv
// Address generator
// Base plus index scaled by 1, 2, 4 or 8, used for
// loads, stores and LEA
`timescale 1ns/1ps

module exAddrGen import exPkg::*; (
	input  logic [AddrWidth-1:0] base,
	input  logic [AddrWidth-1:0] index,
	input  logic [1:0]           scale,
	output logic [AddrWidth-1:0] addr
);

	logic [AddrWidth-1:0] scaledIndex;

	always_comb begin
		case (scale)
			2'd0: scaledIndex = index;
			2'd1: scaledIndex = {index[AddrWidth-2:0], 1'b0};
			2'd2: scaledIndex = {index[AddrWidth-3:0], 2'b0};
			default: scaledIndex = {index[AddrWidth-4:0], 3'b0};	// Quadword
		endcase
	end

	// Wraps at 32 bits
	assign addr = base + scaledIndex;

endmodule

// File: rtl/exShifter.sv
// Bidirectional 64-bit barrel shifter
// Signed amount picks direction, positive shifts left,
// arith selects sign fill on right shifts
// Magnitudes of 64 or more saturate
`timescale 1ns/1ps

module exShifter import exPkg::*; (
	input  logic [DataWidth-1:0] value,
	input  logic [7:0]           amount,
	input  logic                 arith,
	output logic [DataWidth-1:0] result
);

	logic       goRight;
	logic [7:0] magnitude;
	logic       fill;

	assign goRight = amount[7];
	// -128 gives 128 here, which saturates as it should
	assign magnitude = goRight ? (~amount + 8'd1) : amount;
	assign fill = arith & value[DataWidth-1];

	always_comb begin
		if (magnitude >= 8'd64) begin
			if (goRight)
				result = {DataWidth{fill}};
			else
				result = '0;
		end else if (!goRight) begin
			result = value << magnitude[5:0];
		end else if (arith) begin
			result = $signed(value) >>> magnitude[5:0];
		end else begin
			result = value >> magnitude[5:0];
		end
	end

endmodule

// File: ex1/exStage1.sv
// EX1 execute stage
// Checks the condition code against SR.T, executes register,
// compare, branch and trap ops, starts memory ops and keeps SP
// Sends one queue entry per accepted op under credit flow control
`timescale 1ns/1ps

module exStage1 import exPkg::*; (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  opValid,
	output logic                  opReady,
	input  logic [7:0]            opUCmd,
	input  logic [7:0]            opUIxt,
	input  logic [RegIdWidth-1:0] regIdRm,
	input  logic [DataWidth-1:0]  regValRs,
	input  logic [DataWidth-1:0]  regValRt,
	input  logic [DataWidth-1:0]  regValRm,
	input  logic [32:0]           regValImm,
	input  logic [AddrWidth-1:0]  regValPc,
	output logic                  exValid,
	output logic [1:0]            exKind,
	output logic [RegIdWidth-1:0] exRegId,
	output logic [DataWidth-1:0]  exValue,
	output logic [MemIdxWidth-1:0] exAddr,
	output logic [DataWidth-1:0]  exData,
	input  logic                  creditReturn,
	output logic                  braValid,
	output logic [AddrWidth-1:0]  braTarget,
	output logic                  trapValid,
	output logic [15:0]           trapCode
);

	logic [CreditWidth-1:0] creditCount;
	logic                   srT;
	logic [AddrWidth-1:0]   sp;
	logic [AddrWidth-1:0]   spSub8;
	logic [AddrWidth-1:0]   spAdd8;
	logic [AddrWidth-1:0]   aguAddr;
	logic [DataWidth-1:0]   shiftResult;
	logic                   opEnable;
	logic [5:0]             cmd;
	logic                   accept;

	// Next-state values for the accepted op
	logic [1:0]             nKind;
	logic [RegIdWidth-1:0]  nRegId;
	logic [DataWidth-1:0]   nValue;
	logic [MemIdxWidth-1:0] nAddr;
	logic [DataWidth-1:0]   nData;
	logic                   nT;
	logic [AddrWidth-1:0]   nSp;
	logic                   nBra;
	logic [AddrWidth-1:0]   nBraTarget;
	logic                   nTrap;
	logic [15:0]            nTrapCode;

	exAddrGen agu (
		.base(regValRs[AddrWidth-1:0]),
		.index(regValRt[AddrWidth-1:0]),
		.scale(opUIxt[5:4]),
		.addr(aguAddr)
	);

	exShifter shifter (
		.value(regValRs),
		.amount(regValRt[7:0]),
		.arith(cmd == UcmdShad),
		.result(shiftResult)
	);

	assign opReady = (creditCount != '0);
	assign accept = opValid && opReady;
	assign spSub8 = sp - 32'd8;
	assign spAdd8 = sp + 32'd8;

	always_comb begin
		case (opUCmd[7:6])
			CcAlways: opEnable = 1'b1;
			CcNever: opEnable = 1'b0;
			CcTrue: opEnable = srT;
			CcFalse: opEnable = !srT;
		endcase
	end

	// Disabled ops become NOP
	assign cmd = opEnable ? opUCmd[5:0] : UcmdNop;

	always_comb begin
		nKind = KindNone;
		nRegId = RegZero;
		nValue = '0;
		nAddr = aguAddr[MemIdxWidth+2:3];	// Quadword index
		nData = regValRm;
		nT = srT;
		nSp = sp;
		nBra = 1'b0;
		nBraTarget = regValPc + regValImm[AddrWidth-1:0];
		nTrap = 1'b0;
		nTrapCode = TrapInvalid;
		case (cmd)
			UcmdNop: begin
			end
			UcmdInvop: nTrap = 1'b1;
			UcmdLea: begin
				nKind = KindReg;
				nRegId = regIdRm;
				nValue = {{(DataWidth-AddrWidth){1'b0}}, aguAddr};
			end
			UcmdStore: nKind = KindStore;
			UcmdLoad: begin
				nKind = KindLoad;
				nRegId = regIdRm;
			end
			UcmdPush: begin
				// Predecrement, store lands at the new SP
				nKind = KindStore;
				nAddr = spSub8[MemIdxWidth+2:3];
				nData = regValRs;
				nSp = spSub8;
			end
			UcmdPop: begin
				nKind = KindLoad;
				nRegId = regIdRm;
				nAddr = sp[MemIdxWidth+2:3];
				nSp = spAdd8;
			end
			UcmdMovIr: begin
				nKind = KindReg;
				nRegId = regIdRm;
				if (opUIxt[0])
					nValue = {regValRs[DataWidth-17:0], regValImm[15:0]};	// LDISH16
				else
					nValue = {{(DataWidth-33){regValImm[32]}}, regValImm};
			end
			UcmdShad, UcmdShld: begin
				nKind = KindReg;
				nRegId = regIdRm;
				nValue = shiftResult;
			end
			UcmdCmpEq: nT = (regValRs == regValRt);
			UcmdBra: nBra = 1'b1;
			UcmdJmp: begin
				nBra = 1'b1;
				nBraTarget = regValRs[AddrWidth-1:0];
			end
			UcmdOpIxt: begin
				case (opUIxt[5:0])
					IxtClrt: nT = 1'b0;
					IxtSett: nT = 1'b1;
					IxtNott: nT = !srT;
					IxtMovt: begin
						nKind = KindReg;
						nRegId = regIdRm;
						nValue = {{(DataWidth-1){1'b0}}, srT};
					end
					IxtTrapa: begin
						nTrap = 1'b1;
						nTrapCode = TrapTrapa | {12'h000, regIdRm[3:0]};
					end
					default: nTrap = 1'b1;
				endcase
			end
			default: nTrap = 1'b1;	// Unknown opcode
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			exValid <= 1'b0;
			braValid <= 1'b0;
			trapValid <= 1'b0;
			srT <= 1'b0;
			sp <= SpReset;
			creditCount <= CreditWidth'(QueueDepth);
		end else begin
			exValid <= accept;
			braValid <= accept && nBra;
			trapValid <= accept && nTrap;
			if (accept) begin
				srT <= nT;
				sp <= nSp;
			end
			// Send and return may land on the same edge
			case ({accept, creditReturn})
				2'b10: creditCount <= creditCount - 1'b1;
				2'b01: creditCount <= creditCount + 1'b1;
				default: creditCount <= creditCount;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			exKind <= nKind;
			exRegId <= nRegId;
			exValue <= nValue;
			exAddr <= nAddr;
			exData <= nData;
			braTarget <= nBraTarget;
			trapCode <= nTrapCode;
		end
	end

endmodule

// File: ex2/exMemQueue.sv
// EX1 to EX2 entry FIFO
// Circular buffer of QueueDepth entries, head read straight
// from the entry registers; credits guarantee free space on push
`timescale 1ns/1ps

module exMemQueue import exPkg::*; (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   push,
	input  logic [1:0]             pushKind,
	input  logic [RegIdWidth-1:0]  pushRegId,
	input  logic [DataWidth-1:0]   pushValue,
	input  logic [MemIdxWidth-1:0] pushAddr,
	input  logic [DataWidth-1:0]   pushData,
	input  logic                   pop,
	output logic                   headValid,
	output logic [1:0]             headKind,
	output logic [RegIdWidth-1:0]  headRegId,
	output logic [DataWidth-1:0]   headValue,
	output logic [MemIdxWidth-1:0] headAddr,
	output logic [DataWidth-1:0]   headData
);

	logic [1:0]             kindMem [QueueDepth];
	logic [RegIdWidth-1:0]  regIdMem [QueueDepth];
	logic [DataWidth-1:0]   valueMem [QueueDepth];
	logic [MemIdxWidth-1:0] addrMem [QueueDepth];
	logic [DataWidth-1:0]   dataMem [QueueDepth];

	// Depth is a power of two, pointers wrap on overflow
	logic [QueuePtrWidth-1:0] wrPtr;
	logic [QueuePtrWidth-1:0] rdPtr;
	logic [CreditWidth-1:0]   count;

	assign headValid = (count != '0);
	assign headKind = kindMem[rdPtr];
	assign headRegId = regIdMem[rdPtr];
	assign headValue = valueMem[rdPtr];
	assign headAddr = addrMem[rdPtr];
	assign headData = dataMem[rdPtr];

	always_ff @(posedge clock) begin
		if (push) begin
			kindMem[wrPtr] <= pushKind;
			regIdMem[wrPtr] <= pushRegId;
			valueMem[wrPtr] <= pushValue;
			addrMem[wrPtr] <= pushAddr;
			dataMem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: ex2/exStage2.sv
// EX2 memory completion stage
// Retires queue entries in order against a 256-word scratchpad
// Register entries write back directly, loads take an address
// phase and a data phase, each pop returns one credit to EX1
`timescale 1ns/1ps

module exStage2 import exPkg::*; (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   exValid,
	input  logic [1:0]             exKind,
	input  logic [RegIdWidth-1:0]  exRegId,
	input  logic [DataWidth-1:0]   exValue,
	input  logic [MemIdxWidth-1:0] exAddr,
	input  logic [DataWidth-1:0]   exData,
	output logic                   creditReturn,
	output logic                   wbValid,
	output logic [RegIdWidth-1:0]  wbId,
	output logic [DataWidth-1:0]   wbValue
);

	logic                   headValid;
	logic [1:0]             headKind;
	logic [RegIdWidth-1:0]  headRegId;
	logic [DataWidth-1:0]   headValue;
	logic [MemIdxWidth-1:0] headAddr;
	logic [DataWidth-1:0]   headData;
	logic                   pop;
	logic                   headIsLoad;
	logic                   loadPhase;	// Set during a load's data phase
	logic [DataWidth-1:0]   readData;

	logic [DataWidth-1:0] scratch [MemWords];

	exMemQueue queue (
		.clock(clock),
		.rst(rst),
		.push(exValid),
		.pushKind(exKind),
		.pushRegId(exRegId),
		.pushValue(exValue),
		.pushAddr(exAddr),
		.pushData(exData),
		.pop(pop),
		.headValid(headValid),
		.headKind(headKind),
		.headRegId(headRegId),
		.headValue(headValue),
		.headAddr(headAddr),
		.headData(headData)
	);

	assign headIsLoad = (headKind == KindLoad);

	// Loads hold the head one extra cycle for the read
	assign pop = headValid && (!headIsLoad || loadPhase);
	assign creditReturn = pop;

	// Synchronous read, result valid in the data phase
	always_ff @(posedge clock) begin
		readData <= scratch[headAddr];
		if (pop && headKind == KindStore)
			scratch[headAddr] <= headData;
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			loadPhase <= 1'b0;
			wbValid <= 1'b0;
		end else begin
			if (headValid && headIsLoad)
				loadPhase <= !loadPhase;
			wbValid <= pop && (headKind == KindReg || headIsLoad);
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			wbId <= headRegId;
			wbValue <= headIsLoad ? readData : headValue;
		end
	end

endmodule

// File: rtl/exCore.sv
// Execute back end top level
// EX1 feeds EX2 through the credit-controlled entry queue;
// branch and trap requests leave from EX1, writeback from EX2
`timescale 1ns/1ps

module exCore import exPkg::*; (
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  opValid,
	output logic                  opReady,
	input  logic [7:0]            opUCmd,
	input  logic [7:0]            opUIxt,
	input  logic [RegIdWidth-1:0] regIdRm,
	input  logic [DataWidth-1:0]  regValRs,
	input  logic [DataWidth-1:0]  regValRt,
	input  logic [DataWidth-1:0]  regValRm,
	input  logic [32:0]           regValImm,
	input  logic [AddrWidth-1:0]  regValPc,
	output logic                  braValid,
	output logic [AddrWidth-1:0]  braTarget,
	output logic                  trapValid,
	output logic [15:0]           trapCode,
	output logic                  wbValid,
	output logic [RegIdWidth-1:0] wbId,
	output logic [DataWidth-1:0]  wbValue
);

	logic                   exValid;
	logic [1:0]             exKind;
	logic [RegIdWidth-1:0]  exRegId;
	logic [DataWidth-1:0]   exValue;
	logic [MemIdxWidth-1:0] exAddr;
	logic [DataWidth-1:0]   exData;
	logic                   creditReturn;

	exStage1 ex1 (
		.clock(clock), .rst(rst),
		.opValid(opValid), .opReady(opReady),
		.opUCmd(opUCmd), .opUIxt(opUIxt),
		.regIdRm(regIdRm), .regValRs(regValRs), .regValRt(regValRt),
		.regValRm(regValRm), .regValImm(regValImm), .regValPc(regValPc),
		.exValid(exValid), .exKind(exKind), .exRegId(exRegId),
		.exValue(exValue), .exAddr(exAddr), .exData(exData),
		.creditReturn(creditReturn),
		.braValid(braValid), .braTarget(braTarget),
		.trapValid(trapValid), .trapCode(trapCode)
	);

	exStage2 ex2 (
		.clock(clock), .rst(rst),
		.exValid(exValid), .exKind(exKind), .exRegId(exRegId),
		.exValue(exValue), .exAddr(exAddr), .exData(exData),
		.creditReturn(creditReturn),
		.wbValid(wbValid), .wbId(wbId), .wbValue(wbValue)
	);

endmodule

// File: bench/exCore_asserts.sv
// Credit and side-channel checks for EX1
// Bound into exStage1 to watch credit use and branch/trap pulses
`timescale 1ns/1ps

module exCoreAsserts import exPkg::*; (
	input logic                   clock,
	input logic                   rst,
	input logic                   exValid,
	input logic                   creditReturn,
	input logic [CreditWidth-1:0] creditCount,
	input logic                   braValid,
	input logic                   trapValid
);

	logic [7:0] inFlight;	// Entries sent whose credit is not yet back
	int         failCount = 0;	// Assertion failures so far

	always_ff @(posedge clock) begin
		if (rst)
			inFlight <= '0;
		else
			inFlight <= inFlight + exValid - creditReturn;
	end

	// Outstanding entries before this one must leave a free slot
	sendNeedsCredit: assert property (@(posedge clock) disable iff (rst)
		exValid |-> inFlight < QueueDepth)
		else begin
			$error("Entry sent while EX1 held no credit");
			failCount++;
		end

	creditInRange: assert property (@(posedge clock) disable iff (rst)
		creditCount <= QueueDepth)
		else begin
			$error("Credit count above queue depth: %0d", creditCount);
			failCount++;
		end

	returnBounded: assert property (@(posedge clock) disable iff (rst)
		creditReturn |-> inFlight != '0)
		else begin
			$error("Credit returned with no entry outstanding");
			failCount++;
		end

	sideExclusive: assert property (@(posedge clock) disable iff (rst)
		!(braValid && trapValid))
		else begin
			$error("Branch and trap raised in the same cycle");
			failCount++;
		end

endmodule

bind exStage1 exCoreAsserts checks (
	.clock(clock), .rst(rst), .exValid(exValid), .creditReturn(creditReturn),
	.creditCount(creditCount), .braValid(braValid), .trapValid(trapValid)
);

// File: bench/exCoreTb.sv
// Testbench for the execute back end
// Drives directed and random ops into EX1, predicts writeback,
// branch and trap results with a reference model of T, SP and memory
`timescale 1ns/1ps

module exCoreTb import exPkg::*; ();

	logic        clock, rst, opValid, opReady;
	logic [7:0]  opUCmd, opUIxt;
	logic [5:0]  regIdRm, wbId;
	logic [63:0] regValRs, regValRt, regValRm, wbValue;
	logic [32:0] regValImm;
	logic [31:0] regValPc, braTarget;
	logic        braValid, trapValid, wbValid;
	logic [15:0] trapCode;

	// Reference model state
	logic        modelT;
	logic [31:0] modelSp;
	logic [63:0] modelMem [MemWords];
	logic [69:0] expWb [$];	// {id, value}
	logic [49:0] expSide [$];	// {bra, target, trap, code} for every op

	integer      seed, errorCount, checkCount, testCount, errorsBefore;
	integer      opsIssued, stallCycles, stallsBefore, cycleCount, i;
	logic        acceptPrev;
	logic [49:0] side;
	logic [69:0] wbExp;
	logic [63:0] rs, rt;
	logic [1:0]  cc;
	logic [7:0]  storedIdx [8];
	logic [7:0]  shiftAmts [6];

	exCore uut (
		.clock(clock), .rst(rst), .opValid(opValid), .opReady(opReady),
		.opUCmd(opUCmd), .opUIxt(opUIxt), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt), .regValRm(regValRm),
		.regValImm(regValImm), .regValPc(regValPc),
		.braValid(braValid), .braTarget(braTarget),
		.trapValid(trapValid), .trapCode(trapCode),
		.wbValid(wbValid), .wbId(wbId), .wbValue(wbValue)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic logic [5:0] randRm();
		return 6'(({$random(seed)} % 63) + 1);	// Never register 0
	endfunction

	// Base register that lands on word slot after the scaled index is added
	function automatic logic [63:0] baseFor(input logic [7:0] slot, input logic [63:0] index,
		input logic [1:0] scale);
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		lo = {lo[31:11], slot, lo[2:0]} - (index[31:0] << scale);
		return {hi, lo};
	endfunction

	// One bit per step so saturation falls out of the loop count
	function automatic logic [63:0] shiftRef(input logic [63:0] v, input logic [7:0] rawAmt,
		input logic arith);
		integer amt;
		logic [63:0] r;
		amt = $signed(rawAmt);
		r = v;
		if (amt >= 0)
			repeat (amt) r = r << 1;
		else
			repeat (-amt) r = arith ? {r[63], r[63:1]} : {1'b0, r[63:1]};
		return r;
	endfunction

	function automatic void refExec(input logic [7:0] uCmd, input logic [7:0] uIxt,
		input logic [5:0] rm, input logic [63:0] rsv, input logic [63:0] rtv,
		input logic [63:0] rmVal, input logic [32:0] imm, input logic [31:0] pc);
		logic        enabled, hasWb, isBra, isTrap;
		logic [31:0] ea, braTgt;
		logic [63:0] wbVal, immExt;
		logic [15:0] code;
		hasWb = 1'b0;
		isBra = 1'b0;
		isTrap = 1'b0;
		wbVal = '0;
		braTgt = '0;
		code = '0;
		immExt = {{31{imm[32]}}, imm};
		ea = rsv[31:0] + (rtv[31:0] << uIxt[5:4]);
		case (uCmd[7:6])
			CcAlways: enabled = 1'b1;
			CcNever: enabled = 1'b0;
			CcTrue: enabled = modelT;
			default: enabled = !modelT;
		endcase
		if (enabled) begin
			case (uCmd[5:0])
				UcmdNop: ;
				UcmdLea: begin
					hasWb = 1'b1;
					wbVal = {32'h0, ea};
				end
				UcmdStore: modelMem[ea[10:3]] = rmVal;
				UcmdLoad: begin
					hasWb = 1'b1;
					wbVal = modelMem[ea[10:3]];
				end
				UcmdPush: begin
					modelSp = modelSp - 32'd8;
					modelMem[modelSp[10:3]] = rsv;
				end
				UcmdPop: begin
					hasWb = 1'b1;
					wbVal = modelMem[modelSp[10:3]];
					modelSp = modelSp + 32'd8;
				end
				UcmdMovIr: begin
					hasWb = 1'b1;
					wbVal = uIxt[0] ? {rsv[47:0], imm[15:0]} : immExt;
				end
				UcmdShad, UcmdShld: begin
					hasWb = 1'b1;
					wbVal = shiftRef(rsv, rtv[7:0], uCmd[5:0] == UcmdShad);
				end
				UcmdCmpEq: modelT = (rsv == rtv);
				UcmdBra: begin
					isBra = 1'b1;
					braTgt = pc + immExt[31:0];
				end
				UcmdJmp: begin
					isBra = 1'b1;
					braTgt = rsv[31:0];
				end
				UcmdOpIxt: begin
					case (uIxt[5:0])
						IxtClrt: modelT = 1'b0;
						IxtSett: modelT = 1'b1;
						IxtNott: modelT = !modelT;
						IxtMovt: begin
							hasWb = 1'b1;
							wbVal = {63'h0, modelT};
						end
						IxtTrapa: begin
							isTrap = 1'b1;
							code = 16'hC080 + rm[3:0];
						end
						default: begin
							isTrap = 1'b1;
							code = TrapInvalid;
						end
					endcase
				end
				default: begin
					isTrap = 1'b1;
					code = TrapInvalid;
				end
			endcase
		end
		if (hasWb)
			expWb.push_back({rm, wbVal});
		expSide.push_back({isBra, braTgt, isTrap, code});
	endfunction

	// Present an op and hold it until EX1 takes it
	task automatic issueOp(input logic [7:0] uCmd, input logic [7:0] uIxt, input logic [5:0] rm,
		input logic [63:0] rsv, input logic [63:0] rtv, input logic [63:0] rmVal,
		input logic [32:0] imm, input logic [31:0] pc);
		opValid = 1'b1;
		opUCmd = uCmd;
		opUIxt = uIxt;
		regIdRm = rm;
		regValRs = rsv;
		regValRt = rtv;
		regValRm = rmVal;
		regValImm = imm;
		regValPc = pc;
		@(negedge clock);
		while (!opReady) begin
			stallCycles++;
			@(negedge clock);
		end
		refExec(uCmd, uIxt, rm, rsv, rtv, rmVal, imm, pc);
		opsIssued++;
		@(posedge clock);
		#10;
	endtask

	task automatic loadSlot(input logic [7:0] slot);
		logic [63:0] t;
		logic [1:0] s;
		t = rand64();
		s = $random(seed);
		issueOp({CcAlways, UcmdLoad}, {2'b00, s, 4'h0}, randRm(), baseFor(slot, t, s), t,
			0, 0, 0);
	endtask

	task automatic storeSlot(input logic [7:0] slot);
		logic [63:0] t;
		logic [1:0] s;
		t = rand64();
		s = $random(seed);
		issueOp({CcAlways, UcmdStore}, {2'b00, s, 4'h0}, 6'd0, baseFor(slot, t, s), t,
			rand64(), 0, 0);
	endtask

	task automatic endTest(input string name);
		opValid = 1'b0;
		while (expWb.size() != 0)
			@(posedge clock);
		repeat (10) @(posedge clock);
		#10;
		testCount++;
		$display("Test %0d %s done, %0d errors", testCount, name, errorCount - errorsBefore);
		errorsBefore = errorCount;
	endtask

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		checkCount++;
		assert (got === exp) else begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	// Compares mid-cycle where outputs are settled
	always @(negedge clock) begin
		if (rst) begin
			acceptPrev = 1'b0;
		end else begin
			side = (acceptPrev && expSide.size() != 0) ? expSide.pop_front() : '0;
			checkValue("braValid", braValid, side[49]);
			if (side[49])
				checkValue("braTarget", braTarget, side[48:17]);
			checkValue("trapValid", trapValid, side[16]);
			if (side[16])
				checkValue("trapCode", trapCode, side[15:0]);
			if (wbValid) begin
				checkCount++;
				assert (expWb.size() != 0) else begin
					$display("Unexpected writeback to register %0d with no op pending", wbId);
					errorCount++;
				end
				if (expWb.size() != 0) begin
					wbExp = expWb.pop_front();
					checkValue("wbId", wbId, wbExp[69:64]);
					checkValue("wbValue", wbValue, wbExp[63:0]);
				end
			end
			acceptPrev = opValid && opReady;	// Taken on the coming edge
		end
	end

	// Limit grows by 40 cycles for every issued op
	initial begin
		cycleCount = 0;
		opsIssued = 0;
		while (cycleCount <= 40 * (opsIssued + 1)) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, %0d writebacks still pending", cycleCount,
			expWb.size());
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		seed = 54;
		rst = 1'b1;
		opValid = 1'b0;
		opUCmd = '0;
		opUIxt = '0;
		regIdRm = '0;
		regValRs = '0;
		regValRt = '0;
		regValRm = '0;
		regValImm = '0;
		regValPc = '0;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		errorsBefore = 0;
		stallCycles = 0;
		modelT = 1'b0;
		modelSp = 32'h800;
		shiftAmts = '{8'd0, 8'd63, 8'd64, 8'hC1, 8'hC0, 8'h80};
		repeat (2) @(posedge clock);
		#10;
		rst = 1'b0;

		for (i = 0; i < 20; i++) begin
			rs = rand64();
			rt = rand64();
			cc = $random(seed);	// Scale for LEA
			case ({$random(seed)} % 5)
				0: issueOp({CcAlways, UcmdMovIr}, 8'h00, randRm(), rs, rt, 0, 33'(rt), 0);
				1: issueOp({CcAlways, UcmdMovIr}, 8'h01, randRm(), rs, rt, 0, 33'(rt), 0);
				2: issueOp({CcAlways, UcmdLea}, {2'b00, cc, 4'h0}, randRm(), rs, rt, 0, 0, 0);
				3: issueOp({CcAlways, UcmdShad}, 8'h00, randRm(), rs, rt, 0, 0, 0);
				default: issueOp({CcAlways, UcmdShld}, 8'h00, randRm(), rs, rt, 0, 0, 0);
			endcase
		end
		for (i = 0; i < 6; i++) begin
			rs = rand64() | {1'b1, 63'h0};	// Negative value shows the sign fill
			rt = {56'h0, shiftAmts[i]};
			issueOp({CcAlways, UcmdShad}, 8'h00, randRm(), rs, rt, 0, 0, 0);
			issueOp({CcAlways, UcmdShld}, 8'h00, randRm(), rs, rt, 0, 0, 0);
		end
		endTest("register ops");

		issueOp({CcAlways, UcmdOpIxt}, {2'b00, IxtSett}, 6'd1, 0, 0, 0, 0, 0);
		issueOp({CcAlways, UcmdOpIxt}, {2'b00, IxtMovt}, 6'd2, 0, 0, 0, 0, 0);
		issueOp({CcAlways, UcmdOpIxt}, {2'b00, IxtClrt}, 6'd3, 0, 0, 0, 0, 0);
		issueOp({CcAlways, UcmdOpIxt}, {2'b00, IxtMovt}, 6'd4, 0, 0, 0, 0, 0);
		issueOp({CcAlways, UcmdOpIxt}, {2'b00, IxtNott}, 6'd5, 0, 0, 0, 0, 0);
		issueOp({CcAlways, UcmdOpIxt}, {2'b00, IxtMovt}, 6'd6, 0, 0, 0, 0, 0);
		rs = rand64();
		issueOp({CcAlways, UcmdCmpEq}, 8'h00, 6'd7, rs, rs, 0, 0, 0);
		issueOp({CcAlways, UcmdCmpEq}, 8'h00, 6'd8, rs, ~rs, 0, 0, 0);
		for (i = 0; i < 24; i++) begin
			cc = $random(seed);
			rs = rand64();
			rt = ($random(seed) & 1) ? rs : rand64();
			case ({$random(seed)} % 6)
				0: issueOp({cc, UcmdMovIr}, 8'h00, randRm(), rs, rt, 0, 33'(rt), 0);
				1: issueOp({cc, UcmdOpIxt}, {2'b00, IxtMovt}, randRm(), rs, rt, 0, 0, 0);
				2: issueOp({cc, UcmdOpIxt}, {2'b00, IxtNott}, randRm(), rs, rt, 0, 0, 0);
				3: issueOp({cc, UcmdBra}, 8'h00, randRm(), rs, rt, 0, 33'(rt), rs[31:0]);
				4: issueOp({cc, UcmdOpIxt}, {2'b00, IxtTrapa}, randRm(), rs, rt, 0, 0, 0);
				default: issueOp({cc, UcmdCmpEq}, 8'h00, randRm(), rs, rt, 0, 0, 0);
			endcase
		end
		endTest("condition codes");

		for (i = 0; i < 8; i++) begin
			storedIdx[i] = $random(seed);
			storeSlot(storedIdx[i]);
		end
		for (i = 0; i < 12; i++)
			loadSlot(storedIdx[{$random(seed)} % 8]);
		for (i = 0; i < 6; i++)
			issueOp({CcAlways, UcmdPush}, 8'h00, 6'd0, rand64(), 0, 0, 0, 0);
		for (i = 0; i < 6; i++)
			issueOp({CcAlways, UcmdPop}, 8'h00, randRm(), 0, 0, 0, 0, 0);
		endTest("memory");

		for (i = 0; i < 3; i++) begin
			issueOp({CcAlways, UcmdBra}, 8'h00, randRm(), 0, 0, 0, 33'(rand64()), $random(seed));
			issueOp({CcAlways, UcmdJmp}, 8'h00, randRm(), rand64(), 0, 0, 0, 0);
			issueOp({CcAlways, UcmdOpIxt}, {2'b00, IxtTrapa}, randRm(), 0, 0, 0, 0, 0);
			issueOp({CcAlways, UcmdInvop}, 8'h00, randRm(), 0, 0, 0, 0, 0);
			issueOp({CcAlways, 6'h3F}, 8'h00, randRm(), 0, 0, 0, 0, 0);	// Unknown opcode
			issueOp({CcAlways, UcmdOpIxt}, 8'h3A, randRm(), 0, 0, 0, 0, 0);
			issueOp({CcNever, UcmdBra}, 8'h00, randRm(), 0, 0, 0, 33'(rand64()), 0);
		end
		endTest("branches and traps");

		stallsBefore = stallCycles;
		for (i = 0; i < 12; i++)
			loadSlot(storedIdx[{$random(seed)} % 8]);
		checkCount++;
		assert (stallCycles > stallsBefore) else begin
			$display("opReady never fell during the load burst");
			errorCount++;
		end
		endTest("back-pressure");

		errorCount += uut.ex1.checks.failCount;
		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: exCore.f
common/exPkg.sv
rtl/exAddrGen.sv
rtl/exShifter.sv
ex1/exStage1.sv
ex2/exMemQueue.sv
ex2/exStage2.sv
rtl/exCore.sv
bench/exCore_asserts.sv
bench/exCoreTb.sv

// File: Bender.yml
package:
  name: excore

sources:
  - common/exPkg.sv
  - rtl/exAddrGen.sv
  - rtl/exShifter.sv
  - ex1/exStage1.sv
  - ex2/exMemQueue.sv
  - ex2/exStage2.sv
  - rtl/exCore.sv
  - target: test
    files:
      - bench/exCore_asserts.sv
      - bench/exCoreTb.sv
